//--- Makefile
SRCS = dcachePkg.sv cacheArbiter.sv wayArrays.sv ageReplacer.sv lookupStage.sv \
       dcacheTop.sv dcacheTb.sv

.PHONY: all run clean

all: run

obj_dir/VdcacheTb: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module dcacheTb -o VdcacheTb -f vlog.f

run: obj_dir/VdcacheTb
	./obj_dir/VdcacheTb | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf obj_dir

//--- ageReplacer.sv
module ageReplacer #(
    parameter int AgeBits = 3
) (
    input  logic               Clk,
    input  logic               rst,
    input  dcachePkg::stageT   Stage,
    input  logic               HitAble,
    input  dcachePkg::wayMaskT HitWay,
    input  dcachePkg::wayMaskT Valids,
    output dcachePkg::wayMaskT Victim,
    output logic               VictimDirty
);

    localparam int WayIdxBits = $clog2(dcachePkg::NumWays);

    logic [AgeBits-1:0]  ageMem   [dcachePkg::NumSets][dcachePkg::NumWays];
    dcachePkg::wayMaskT  dirtyMem [dcachePkg::NumSets];

    logic [dcachePkg::IndexBits-1:0] idx;
    logic                            isRefill;
    logic                            useAble;
    dcachePkg::wayMaskT              useWay;
    logic [AgeBits-1:0]              bestAge;
    logic [WayIdxBits-1:0]           bestWay;
    logic [WayIdxBits-1:0]           freeWay;
    logic                            anyFree;

    assign idx      = Stage.req.addr.split.index;
    assign isRefill = Stage.kind == dcachePkg::KindRefill;
    assign useAble  = HitAble || isRefill;
    assign useWay   = isRefill ? Stage.refWay : HitWay;

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < dcachePkg::NumSets; s++) begin
                dirtyMem[s] <= '0;
                for (int w = 0; w < dcachePkg::NumWays; w++) begin
                    ageMem[s][w] <= '0;
                end
            end
        end else begin
            if (useAble) begin
                for (int w = 0; w < dcachePkg::NumWays; w++) begin
                    if (useWay[w]) begin
                        ageMem[idx][w] <= '0;
                    end else if (ageMem[idx][w] != '1) begin
                        ageMem[idx][w] <= ageMem[idx][w] + 1'b1; // saturates at all ones
                    end
                end
            end
            if (isRefill) begin
                dirtyMem[idx] <= dirtyMem[idx] & ~Stage.refWay;
            end else if (HitAble && Stage.kind == dcachePkg::KindStore) begin
                dirtyMem[idx] <= dirtyMem[idx] | HitWay;
            end
        end
    end

    // oldest way, strict compare keeps the lowest on a tie
    always_comb begin
        bestAge = ageMem[idx][0];
        bestWay = '0;
        for (int w = 1; w < dcachePkg::NumWays; w++) begin
            if (ageMem[idx][w] > bestAge) begin
                bestAge = ageMem[idx][w];
                bestWay = WayIdxBits'(w);
            end
        end
    end

    always_comb begin
        freeWay = '0;
        for (int w = dcachePkg::NumWays - 1; w >= 0; w--) begin
            if (!Valids[w]) begin
                freeWay = WayIdxBits'(w);
            end
        end
    end

    assign anyFree     = ~&Valids;
    assign Victim      = dcachePkg::wayMaskT'(1) << (anyFree ? freeWay : bestWay);
    assign VictimDirty = |(dirtyMem[idx] & Victim);

endmodule

//--- cacheArbiter.sv
module cacheArbiter (
    input  logic               Clk,
    input  logic               rst,
    input  logic               LoadAble,
    input  dcachePkg::memReqT  LoadReq,
    input  logic               StoreAble,
    input  dcachePkg::memReqT  StoreReq,
    input  logic               RefillAble,
    input  dcachePkg::refillT  Refill,
    output logic               LoadSuccess,
    output logic               StoreSuccess,
    output dcachePkg::stageT   Stage
);

    logic              loadTurn;   // conflict goes to load when set
    logic              grantLoad;
    logic              grantStore;
    logic              conflict;
    logic [1:0]        kindNext;
    dcachePkg::memReqT reqNext;

    assign conflict   = !RefillAble && LoadAble && StoreAble;
    assign grantLoad  = !RefillAble && LoadAble && (!StoreAble || loadTurn);
    assign grantStore = !RefillAble && StoreAble && (!LoadAble || !loadTurn);

    always_comb begin
        kindNext = dcachePkg::KindIdle;
        reqNext  = LoadReq;
        if (RefillAble) begin
            kindNext           = dcachePkg::KindRefill;
            reqNext.addr       = Refill.lineAddr;
            reqNext.data       = '0;
            reqNext.ptr        = '0;
        end else if (grantLoad) begin
            kindNext = dcachePkg::KindLoad;
        end else if (grantStore) begin
            kindNext = dcachePkg::KindStore;
            reqNext  = StoreReq;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            loadTurn     <= 1'b1;
            Stage.kind   <= dcachePkg::KindIdle;
            LoadSuccess  <= 1'b0;
            StoreSuccess <= 1'b0;
        end else begin
            if (conflict) begin
                loadTurn <= !loadTurn;
            end
            Stage.kind   <= kindNext;
            LoadSuccess  <= grantLoad;
            StoreSuccess <= grantStore;
        end
    end

    // payload half of the stage register
    always_ff @(posedge Clk) begin
        Stage.req     <= reqNext;
        Stage.refWay  <= Refill.way;
        Stage.refLine <= Refill.line;
    end

    // only one issuer may believe it was accepted
    assert property (@(posedge Clk) disable iff (rst) !(LoadSuccess && StoreSuccess));

endmodule

//--- dcachePkg.sv
package dcachePkg;

    localparam int NumWays    = 4;
    localparam int IndexBits  = 7;
    localparam int OffsetBits = 5;
    localparam int TagBits    = 20;
    localparam int WordSel    = 3;   // word number inside a line
    localparam int LineBits   = 256;
    localparam int PtrBits    = 3;
    localparam int NumSets    = 1 << IndexBits;
    localparam int DataBits   = 32;

    // stage kind codes
    localparam logic [1:0] KindIdle   = 2'd0;
    localparam logic [1:0] KindLoad   = 2'd1;
    localparam logic [1:0] KindStore  = 2'd2;
    localparam logic [1:0] KindRefill = 2'd3;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TagBits-1:0]              tag;
            logic [IndexBits-1:0]            index;
            logic [WordSel-1:0]              word;
            logic [OffsetBits-WordSel-1:0]   byteOff;
        } split;
    } physAddrT;

    typedef logic [NumWays-1:0] wayMaskT;

    typedef struct packed {
        physAddrT              addr;
        logic [DataBits-1:0]   data;   // ignored on loads
        logic [PtrBits-1:0]    ptr;
    } memReqT;

    typedef struct packed {
        physAddrT              lineAddr;
        wayMaskT               way;    // one-hot
        logic [LineBits-1:0]   line;
    } refillT;

    typedef struct packed {
        logic [1:0]            kind;
        memReqT                req;    // refill line address rides in req.addr
        wayMaskT               refWay;
        logic [LineBits-1:0]   refLine;
    } stageT;

    typedef struct packed {
        logic [PtrBits-1:0]    ptr;
        logic [DataBits-1:0]   data;
    } respT;

    typedef struct packed {
        physAddrT              lineAddr;
        wayMaskT               way;
        logic [PtrBits-1:0]    ptr;
    } missT;

    typedef struct packed {
        physAddrT              lineAddr;
        logic [LineBits-1:0]   line;
    } wbT;

endpackage

//--- dcacheTb.sv
module dcacheTb;
    timeunit 1ns;
    timeprecision 1ps;

    // 5 tests, the random one dominates
    localparam int CycleLimit = 20 + 60 + 20 + 80 + 150 * 12 + 500;

    typedef struct packed {
        logic         loadBack;
        logic         storeBack;
        logic         missAble;
        logic         wbAble;
        logic [31:0]  data;
        logic [2:0]   ptr;
        logic [31:0]  missAddr;
        logic [3:0]   missWay;
        logic [31:0]  wbAddr;
        logic [255:0] wbLine;
    } expT;

    logic Clk = 1'b0;
    logic rst, LoadAble, StoreAble, RefillAble;
    logic LoadSuccess, StoreSuccess, LoadBack, StoreBack, MissAble, WbAble;
    dcachePkg::memReqT LoadReq, StoreReq;
    dcachePkg::refillT Refill;
    dcachePkg::respT   LoadResp;
    dcachePkg::missT   Miss;
    dcachePkg::wbT     Wb;
    logic [2:0]        StoreBackPtr;

    // reference model state
    logic [19:0]  mTag  [128][4];
    logic [255:0] mLine [128][4];
    bit           mValid[128][4];
    bit           mDirty[128][4];
    int           mAge  [128][4];
    logic [255:0] memImage [logic [26:0]];

    int   errors = 0;
    int   cycles = 0;
    int   tests = 0;
    logic [2:0] ptrNext = '0;
    bit   pendValid = 0;
    expT  pend;

    dcacheTop dut (.*);

    always #20 Clk = !Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles > CycleLimit) begin
            $display("timeout: run went past %0d cycles", CycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] mkAddr(input int tag, input int set, input int word);
        return {20'(tag), 7'(set), 3'(word), 2'b00};
    endfunction

    function automatic logic [255:0] memLine(input logic [31:0] a);
        logic [255:0] l;
        if (memImage.exists(a[31:5])) return memImage[a[31:5]];
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = {a[31:5], 3'(i), 2'b00} ^ 32'h5a3c_9e17; // per word address
        end
        return l;
    endfunction

    function automatic void touchAges(input int s, input int used);
        for (int w = 0; w < 4; w++) begin
            if (w == used) mAge[s][w] = 0;
            else if (mAge[s][w] < 7) mAge[s][w] = mAge[s][w] + 1;
        end
    endfunction

    function automatic void applyRefill(input dcachePkg::refillT r);
        int s;
        s = r.lineAddr.raw[11:5];
        for (int w = 0; w < 4; w++) begin
            if (r.way[w]) begin
                mTag[s][w] = r.lineAddr.raw[31:12];
                mLine[s][w] = r.line;
                mValid[s][w] = 1;
                mDirty[s][w] = 0;
                touchAges(s, w);
            end
        end
    endfunction

    function automatic expT refModel(input bit isStore, input dcachePkg::memReqT req);
        expT e;
        int s;
        int hit;
        int vic;
        logic [31:0] a;
        a = req.addr.raw;
        s = a[11:5];
        e = '0;
        e.ptr = req.ptr;
        hit = -1;
        for (int w = 0; w < 4; w++) begin
            if (mValid[s][w] && mTag[s][w] == a[31:12]) hit = w;
        end
        if (hit >= 0) begin
            touchAges(s, hit);
            if (isStore) begin
                mLine[s][hit][32*a[4:2] +: 32] = req.data;
                mDirty[s][hit] = 1;
                e.storeBack = 1;
            end else begin
                e.loadBack = 1;
                e.data = mLine[s][hit][32*a[4:2] +: 32];
            end
        end else begin
            vic = -1;
            for (int w = 3; w >= 0; w--) if (!mValid[s][w]) vic = w;
            if (vic < 0) begin
                vic = 0;
                for (int w = 1; w < 4; w++) if (mAge[s][w] > mAge[s][vic]) vic = w;
            end
            e.missAble = 1;
            e.missAddr = {a[31:5], 5'b0};
            e.missWay = 4'b1 << vic;
            if (mDirty[s][vic]) begin
                e.wbAble = 1;
                e.wbAddr = {mTag[s][vic], a[11:5], 5'b0};
                e.wbLine = mLine[s][vic];
            end
        end
        return e;
    endfunction

    task automatic checkValue(input string what, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // compare process, outcome lands one cycle after Success
    always @(negedge Clk) begin
        if (!rst) begin
            checkValue("LoadBack", 256'(LoadBack), 256'(pendValid && pend.loadBack));
            checkValue("StoreBack", 256'(StoreBack), 256'(pendValid && pend.storeBack));
            checkValue("MissAble", 256'(MissAble), 256'(pendValid && pend.missAble));
            checkValue("WbAble", 256'(WbAble), 256'(pendValid && pend.wbAble));
            if (pendValid && pend.loadBack) begin
                checkValue("load data", 256'(LoadResp.data), 256'(pend.data));
                checkValue("load ptr", 256'(LoadResp.ptr), 256'(pend.ptr));
            end
            if (pendValid && pend.storeBack)
                checkValue("store ptr", 256'(StoreBackPtr), 256'(pend.ptr));
            if (pendValid && pend.missAble) begin
                checkValue("miss address", 256'(Miss.lineAddr.raw), 256'(pend.missAddr));
                checkValue("miss way", 256'(Miss.way), 256'(pend.missWay));
                checkValue("miss ptr", 256'(Miss.ptr), 256'(pend.ptr));
            end
            if (pendValid && pend.wbAble) begin
                checkValue("wb address", 256'(Wb.lineAddr.raw), 256'(pend.wbAddr));
                checkValue("wb line", Wb.line, pend.wbLine);
            end
            pendValid = 0;
            if (LoadSuccess) begin
                pend = refModel(0, LoadReq);
                pendValid = 1;
            end else if (StoreSuccess) begin
                pend = refModel(1, StoreReq);
                pendValid = 1;
            end
            if (RefillAble) applyRefill(Refill); // sampled after the granted access
            if (WbAble) memImage[Wb.lineAddr.raw[31:5]] = Wb.line;
        end
    end

    task automatic pulseRefill(input logic [31:0] lineAddr, input logic [3:0] way);
        @(posedge Clk);
        #2;
        RefillAble = 1;
        Refill.lineAddr.raw = lineAddr;
        Refill.way = way;
        Refill.line = memLine(lineAddr);
        @(posedge Clk);
        #2;
        RefillAble = 0;
    endtask

    // issue until it hits, refilling from memory on each miss
    task automatic doAccess(input bit isStore, input logic [31:0] a, input logic [31:0] d,
                            output logic [31:0] got);
        bit done;
        logic [31:0] lineAddr;
        logic [3:0] way;
        done = 0;
        while (!done) begin
            @(posedge Clk);
            #2;
            if (isStore) begin
                StoreAble = 1;
                StoreReq = {a, d, ptrNext};
            end else begin
                LoadAble = 1;
                LoadReq = {a, d, ptrNext};
            end
            ptrNext++;
            // drop in the cycle the Success pulse shows
            do begin
                @(posedge Clk);
                #2;
            end while (!(isStore ? StoreSuccess : LoadSuccess));
            LoadAble = 0;
            StoreAble = 0;
            @(posedge Clk);
            @(negedge Clk);
            got = LoadResp.data;
            if (MissAble) begin
                lineAddr = Miss.lineAddr.raw;
                way = Miss.way;
                repeat (2) @(posedge Clk);
                pulseRefill(lineAddr, way);
            end else begin
                done = 1;
            end
        end
    endtask

    task automatic endTest(input string name, input int errStart);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == errStart ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] got;
        logic [255:0] coldLine;
        int errStart;
        void'($urandom(32'h508db0b2));
        rst = 1;
        LoadAble = 0;
        StoreAble = 0;
        RefillAble = 0;
        LoadReq = '0;
        StoreReq = '0;
        Refill = '0;
        repeat (2) @(posedge Clk);
        #2;
        rst = 0;

        errStart = errors;
        doAccess(0, mkAddr(7, 3, 5), 0, got);
        coldLine = memLine(mkAddr(7, 3, 5));
        checkValue("cold load word", 256'(got), 256'(coldLine[5*32 +: 32]));
        endTest("cold load miss", errStart);

        errStart = errors;
        doAccess(1, mkAddr(1, 10, 3), 32'hcafe_0123, got);
        doAccess(0, mkAddr(1, 10, 3), 0, got);
        checkValue("load after store", 256'(got), 256'(32'hcafe_0123));
        for (int t = 2; t <= 5; t++) doAccess(0, mkAddr(t, 10, 0), 0, got); // last evicts tag 1
        doAccess(0, mkAddr(1, 10, 3), 0, got);
        checkValue("reload after wb", 256'(got), 256'(32'hcafe_0123));
        endTest("store hit and write-back", errStart);

        errStart = errors;
        @(posedge Clk);
        #2;
        LoadAble = 1;
        StoreAble = 1;
        LoadReq = {mkAddr(7, 3, 1), 32'h0, 3'd1};
        StoreReq = {mkAddr(7, 3, 2), 32'h1234_5678, 3'd2};
        @(posedge Clk);
        for (int i = 0; i < 4; i++) begin
            @(negedge Clk);
            checkValue("load grant", 256'(LoadSuccess), 256'(i % 2 == 0));
            checkValue("store grant", 256'(StoreSuccess), 256'(i % 2 == 1));
        end
        @(posedge Clk);
        #2;
        RefillAble = 1;
        Refill = {mkAddr(9, 100, 0), 4'b0001, memLine(mkAddr(9, 100, 0))};
        @(posedge Clk);
        #2;
        RefillAble = 0;
        LoadAble = 0;
        StoreAble = 0;
        @(negedge Clk);
        checkValue("grant during refill", 256'(LoadSuccess || StoreSuccess), 256'(0));
        repeat (3) @(posedge Clk);
        endTest("arbitration", errStart);

        errStart = errors;
        for (int t = 1; t <= 5; t++) doAccess(0, mkAddr(t + 20, 20, t), 0, got);
        doAccess(0, mkAddr(22, 20, 0), 0, got);
        doAccess(0, mkAddr(26, 20, 0), 0, got);
        endTest("victim choice", errStart);

        errStart = errors;
        for (int n = 0; n < 150; n++) begin
            doAccess($urandom % 2, mkAddr($urandom % 6, 40 + $urandom % 3, $urandom % 8),
                     $urandom, got);
        end
        repeat (3) @(posedge Clk);
        endTest("random traffic", errStart);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dcacheTop.sv
module dcacheTop (
    input  logic                           Clk,
    input  logic                           rst,
    input  logic                           LoadAble,
    input  dcachePkg::memReqT              LoadReq,
    input  logic                           StoreAble,
    input  dcachePkg::memReqT              StoreReq,
    input  logic                           RefillAble,
    input  dcachePkg::refillT              Refill,
    output logic                           LoadSuccess,
    output logic                           StoreSuccess,
    output logic                           LoadBack,
    output dcachePkg::respT                LoadResp,
    output logic                           StoreBack,
    output logic [dcachePkg::PtrBits-1:0]  StoreBackPtr,
    output logic                           MissAble,
    output dcachePkg::missT                Miss,
    output logic                           WbAble,
    output dcachePkg::wbT                  Wb
);

    dcachePkg::stageT                                        stage;
    logic [dcachePkg::NumWays-1:0][dcachePkg::TagBits-1:0]   tags;
    dcachePkg::wayMaskT                                      valids;
    logic [dcachePkg::NumWays-1:0][dcachePkg::LineBits-1:0]  lines;
    logic                                                    hitAble;
    dcachePkg::wayMaskT                                      hitWay;
    dcachePkg::wayMaskT                                      storeWay;
    logic [dcachePkg::WordSel-1:0]                           storeWord;
    logic [dcachePkg::DataBits-1:0]                          storeData;
    dcachePkg::wayMaskT                                      victim;
    logic                                                    victimDirty;

    cacheArbiter arbiter (
        .Clk(Clk), .rst(rst),
        .LoadAble(LoadAble), .LoadReq(LoadReq),
        .StoreAble(StoreAble), .StoreReq(StoreReq),
        .RefillAble(RefillAble), .Refill(Refill),
        .LoadSuccess(LoadSuccess), .StoreSuccess(StoreSuccess),
        .Stage(stage)
    );

    wayArrays arrays (
        .Clk(Clk), .rst(rst), .Stage(stage),
        .StoreWay(storeWay), .StoreWord(storeWord), .StoreData(storeData),
        .Tags(tags), .Valids(valids), .Lines(lines)
    );

    ageReplacer #(.AgeBits(3)) replacer (
        .Clk(Clk), .rst(rst), .Stage(stage),
        .HitAble(hitAble), .HitWay(hitWay), .Valids(valids),
        .Victim(victim), .VictimDirty(victimDirty)
    );

    lookupStage lookup (
        .Clk(Clk), .rst(rst), .Stage(stage),
        .Tags(tags), .Valids(valids), .Lines(lines),
        .Victim(victim), .VictimDirty(victimDirty),
        .HitAble(hitAble), .HitWay(hitWay),
        .StoreWay(storeWay), .StoreWord(storeWord), .StoreData(storeData),
        .LoadBack(LoadBack), .LoadResp(LoadResp),
        .StoreBack(StoreBack), .StoreBackPtr(StoreBackPtr),
        .MissAble(MissAble), .Miss(Miss),
        .WbAble(WbAble), .Wb(Wb)
    );

endmodule

//--- lookupStage.sv
module lookupStage (
    input  logic                                                    Clk,
    input  logic                                                    rst,
    input  dcachePkg::stageT                                        Stage,
    input  logic [dcachePkg::NumWays-1:0][dcachePkg::TagBits-1:0]   Tags,
    input  dcachePkg::wayMaskT                                      Valids,
    input  logic [dcachePkg::NumWays-1:0][dcachePkg::LineBits-1:0]  Lines,
    input  dcachePkg::wayMaskT                                      Victim,
    input  logic                                                    VictimDirty,
    output logic                                                    HitAble,
    output dcachePkg::wayMaskT                                      HitWay,
    output dcachePkg::wayMaskT                                      StoreWay,
    output logic [dcachePkg::WordSel-1:0]                           StoreWord,
    output logic [dcachePkg::DataBits-1:0]                          StoreData,
    output logic                                                    LoadBack,
    output dcachePkg::respT                                         LoadResp,
    output logic                                                    StoreBack,
    output logic [dcachePkg::PtrBits-1:0]                           StoreBackPtr,
    output logic                                                    MissAble,
    output dcachePkg::missT                                         Miss,
    output logic                                                    WbAble,
    output dcachePkg::wbT                                           Wb
);

    logic                             isAccess;
    logic                             isLoad;
    logic                             isStore;
    dcachePkg::wayMaskT               hitWay;
    logic [dcachePkg::LineBits-1:0]   hitLine;
    logic [dcachePkg::LineBits-1:0]   victimLine;
    logic [dcachePkg::TagBits-1:0]    victimTag;
    logic [dcachePkg::DataBits-1:0]   hitWord;
    logic [7:0]                       wordBase;
    dcachePkg::physAddrT              missAddr;
    dcachePkg::physAddrT              wbAddr;

    assign isLoad   = Stage.kind == dcachePkg::KindLoad;
    assign isStore  = Stage.kind == dcachePkg::KindStore;
    assign isAccess = isLoad || isStore;

    always_comb begin
        hitLine    = '0;
        victimLine = '0;
        victimTag  = '0;
        for (int w = 0; w < dcachePkg::NumWays; w++) begin
            hitWay[w] = isAccess && Valids[w] && Tags[w] == Stage.req.addr.split.tag;
            if (hitWay[w]) begin
                hitLine = hitLine | Lines[w];
            end
            if (Victim[w]) begin
                victimLine = victimLine | Lines[w];
                victimTag  = victimTag | Tags[w];
            end
        end
    end

    assign wordBase = {Stage.req.addr.split.word, 5'd0};
    assign hitWord  = hitLine[wordBase +: dcachePkg::DataBits];

    assign HitAble   = |hitWay;
    assign HitWay    = hitWay;
    assign StoreWay  = isStore ? hitWay : '0;   // write lands at the same edge as the outputs
    assign StoreWord = Stage.req.addr.split.word;
    assign StoreData = Stage.req.data;

    // line addresses, offset cleared
    assign missAddr.raw = {Stage.req.addr.raw[31:dcachePkg::OffsetBits],
                           {dcachePkg::OffsetBits{1'b0}}};
    assign wbAddr.raw   = {victimTag, Stage.req.addr.split.index, {dcachePkg::OffsetBits{1'b0}}};

    always_ff @(posedge Clk) begin
        if (rst) begin
            LoadBack  <= 1'b0;
            StoreBack <= 1'b0;
            MissAble  <= 1'b0;
            WbAble    <= 1'b0;
        end else begin
            LoadBack  <= isLoad && HitAble;
            StoreBack <= isStore && HitAble;
            MissAble  <= isAccess && !HitAble;
            WbAble    <= isAccess && !HitAble && VictimDirty;
        end
    end

    always_ff @(posedge Clk) begin
        LoadResp.ptr  <= Stage.req.ptr;
        LoadResp.data <= hitWord;
        StoreBackPtr  <= Stage.req.ptr;
        Miss.lineAddr <= missAddr;
        Miss.way      <= Victim;
        Miss.ptr      <= Stage.req.ptr;
        Wb.lineAddr   <= wbAddr;
        Wb.line       <= victimLine;
    end

    // refills must never leave one tag in two ways of a set
    assert property (@(posedge Clk) disable iff (rst) $onehot0(hitWay));

endmodule

//--- vlog.f
dcachePkg.sv
cacheArbiter.sv
wayArrays.sv
ageReplacer.sv
lookupStage.sv
dcacheTop.sv
dcacheTb.sv

//--- wayArrays.sv
module wayArrays (
    input  logic                              Clk,
    input  logic                              rst,
    input  dcachePkg::stageT                  Stage,
    input  dcachePkg::wayMaskT                StoreWay,
    input  logic [dcachePkg::WordSel-1:0]     StoreWord,
    input  logic [dcachePkg::DataBits-1:0]    StoreData,
    output logic [dcachePkg::NumWays-1:0][dcachePkg::TagBits-1:0]   Tags,
    output dcachePkg::wayMaskT                Valids,
    output logic [dcachePkg::NumWays-1:0][dcachePkg::LineBits-1:0]  Lines
);

    logic [dcachePkg::TagBits-1:0]  tagMem  [dcachePkg::NumWays][dcachePkg::NumSets];
    logic [dcachePkg::LineBits-1:0] lineMem [dcachePkg::NumWays][dcachePkg::NumSets];
    dcachePkg::wayMaskT             validMem [dcachePkg::NumSets];

    logic [dcachePkg::IndexBits-1:0] idx;
    logic                            refillHere;
    logic [7:0]                      wordBase;   // bit offset of the stored word

    assign idx        = Stage.req.addr.split.index;
    assign refillHere = Stage.kind == dcachePkg::KindRefill;
    assign wordBase   = {StoreWord, 5'd0};

    // reads are combinational at the staged index
    always_comb begin
        for (int w = 0; w < dcachePkg::NumWays; w++) begin
            Tags[w]  = tagMem[w][idx];
            Lines[w] = lineMem[w][idx];
        end
        Valids = validMem[idx];
    end

    always_ff @(posedge Clk) begin
        for (int w = 0; w < dcachePkg::NumWays; w++) begin
            if (refillHere && Stage.refWay[w]) begin
                tagMem[w][idx]  <= Stage.req.addr.split.tag;
                lineMem[w][idx] <= Stage.refLine;
            end else if (StoreWay[w]) begin
                lineMem[w][idx][wordBase +: dcachePkg::DataBits] <= StoreData; // store hit
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < dcachePkg::NumSets; s++) begin
                validMem[s] <= '0;
            end
        end else if (refillHere) begin
            validMem[idx] <= validMem[idx] | Stage.refWay;
        end
    end

    // memory side must name exactly one way
    assert property (@(posedge Clk) disable iff (rst)
        Stage.kind == dcachePkg::KindRefill |-> $onehot(Stage.refWay));

endmodule
